//--- logic/dcont_config.svh
`ifndef DCONT_CONFIG_SVH
`define DCONT_CONFIG_SVH

`define DCONT_ALU_OP_W 12  // MSB index of one-hot ALU op

`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_AND  2
`define ALU_OR   3
`define ALU_XOR  4
`define ALU_NOR  5
`define ALU_SLT  6
`define ALU_SLTU 7
`define ALU_SLL  8
`define ALU_SRL  9
`define ALU_SRA  10
`define ALU_LINK 11
`define ALU_LUI  12

`define WID_NONE 0
`define WID_BYTE 1
`define WID_HALF 2
`define WID_WORD 3

`define SA_REGF    3'd0
`define SA_DBUS    3'd1
`define SA_HOLD    3'd2
`define SA_IMMED   3'd3
`define SA_ALURES  3'd4
`define SA_ALUREGM 3'd5
`define SA_REGCWB  3'd6

`define SB_REGF    3'd0
`define SB_DBUS    3'd1
`define SB_HOLD    3'd2
`define SB_IMMED   3'd3  // Immediate path only
`define SB_ALURES  3'd4
`define SB_ALUREGM 3'd5
`define SB_REGCWB  3'd6

`define SC_ALUREGM 2'd0
`define SC_DBUS    2'd1
`define SC_HOLD    2'd2

`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_COP0     6'b0100??  // COP0 to COP3
`define OP_SPECIAL2 6'h1c
`define OP_JALX     6'h1d
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_SWL      6'h2a
`define OP_LW       6'h23
`define OP_LBU      6'h24
`define OP_LHU      6'h25
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2b
`define OP_SWR      6'h2e
`define OP_LWC1     6'h31
`define OP_LWC2     6'h32
`define OP_LWC3     6'h33
`define OP_SWC1     6'h39
`define OP_SWC2     6'h3a
`define OP_SWC3     6'h3b

`define FN_SHIFT_I 4'b0000  // funct[5:2] of SLL, SRL, SRA
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SRA     6'h03
`define FN_SLLV    6'h04
`define FN_SRLV    6'h06
`define FN_SRAV    6'h07
`define FN_JR      6'h08
`define FN_JALR    6'h09
`define FN_SYSCALL 6'h0c
`define FN_BREAK   6'h0d
`define FN_SUB     6'h22
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_NOR     6'h27
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

`define RI_BLTZAL 5'h10
`define RI_BGEZAL 5'h11

`define CP_MF 5'h00
`define CP_CF 5'h02
`define CP_MT 5'h04
`define CP_CT 5'h06

`define REG_ZERO 5'd0
`define REG_LINK 5'd31

`endif

//--- logic/dcont_pkg.sv
`default_nettype none

`include "dcont_config.svh"

package dcont_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [16:0] immed_t;  // Extended 16-bit field

  typedef logic [`DCONT_ALU_OP_W:0] alu_op_t;  // One-hot

  typedef logic [3:0] width_t;  // One-hot access width

  typedef logic [2:0] sel_a_t;
  typedef logic [2:0] sel_b_t;  // B-register and B-immediate
  typedef logic [1:0] sel_c_t;

endpackage

`default_nettype wire

//--- logic/reg_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module reg_addr_decode (
  input  dcont_pkg::inst_t     inst,
  output dcont_pkg::reg_addr_t rega_addr,
  output dcont_pkg::reg_addr_t regb_addr,
  output dcont_pkg::reg_addr_t regc_addr_s,
  output logic                 regc_write_s
);
  import dcont_pkg::*;

  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  logic      wr_class;  // Opcode class writes a register

  assign rs = inst[25:21];
  assign rt = inst[20:16];
  assign rd = inst[15:11];

  assign rega_addr = rs;
  assign regb_addr = rt;

  always_comb begin
    case (inst[31:26])
      `OP_SPECIAL:                   regc_addr_s = rd;
      `OP_REGIMM, `OP_JAL, `OP_JALX: regc_addr_s = `REG_LINK;
      default:                       regc_addr_s = rt;
    endcase
  end

  always_comb begin
    casez (inst[31:26])
      `OP_SPECIAL:
        wr_class = !(inst[5:0] inside {`FN_JR, `FN_SYSCALL, `FN_BREAK});
      `OP_REGIMM:
        wr_class = (rt == `RI_BLTZAL) || (rt == `RI_BGEZAL);  // Linking branches only
      `OP_J, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ:
        wr_class = 1'b0;
      `OP_JAL, `OP_JALX:
        wr_class = 1'b1;
      `OP_COP0:
        wr_class = (rs == `CP_MF) || (rs == `CP_CF);
      `OP_LWC1, `OP_LWC2, `OP_LWC3:
        wr_class = 1'b0;  // Loads into coprocessor
      `OP_SB, `OP_SH, `OP_SWL, `OP_SW, `OP_SWR, `OP_SWC1, `OP_SWC2, `OP_SWC3:
        wr_class = 1'b0;
      default:
        wr_class = 1'b1;
    endcase
  end

  assign regc_write_s = wr_class && (regc_addr_s != `REG_ZERO);

endmodule

`default_nettype wire

//--- logic/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module exec_decode (
  input  dcont_pkg::inst_t  inst,
  output dcont_pkg::alu_op_t alu_op,
  output dcont_pkg::immed_t  immed,
  output dcont_pkg::width_t  width,
  output dcont_pkg::sel_c_t  selc_s,
  output logic               dsign_s,
  output logic               dread_s,
  output logic               dwrite_s,
  output logic               rdb_drive_s,
  output logic               a_immed,
  output logic               bi_immed
);
  import dcont_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rs;
  reg_addr_t  rt;

  assign opcode = inst[31:26];
  assign funct  = inst[5:0];
  assign rs     = inst[25:21];
  assign rt     = inst[20:16];

  always_comb begin
    alu_op = '0;
    case (opcode)
      `OP_SPECIAL:
        case (funct)
          `FN_SLL, `FN_SLLV: alu_op[`ALU_SLL] = 1'b1;
          `FN_SRL, `FN_SRLV: alu_op[`ALU_SRL] = 1'b1;
          `FN_SRA, `FN_SRAV: alu_op[`ALU_SRA] = 1'b1;
          `FN_JALR:          alu_op[`ALU_LINK] = 1'b1;
          `FN_SUB, `FN_SUBU: alu_op[`ALU_SUB] = 1'b1;
          `FN_AND:           alu_op[`ALU_AND] = 1'b1;
          `FN_OR:            alu_op[`ALU_OR] = 1'b1;
          `FN_XOR:           alu_op[`ALU_XOR] = 1'b1;
          `FN_NOR:           alu_op[`ALU_NOR] = 1'b1;
          `FN_SLT:           alu_op[`ALU_SLT] = 1'b1;
          `FN_SLTU:          alu_op[`ALU_SLTU] = 1'b1;
          default:           alu_op[`ALU_ADD] = 1'b1;
        endcase
      `OP_REGIMM:
        if ((rt == `RI_BLTZAL) || (rt == `RI_BGEZAL))
          alu_op[`ALU_LINK] = 1'b1;
        else
          alu_op[`ALU_XOR] = 1'b1;
      `OP_JAL, `OP_JALX:                      alu_op[`ALU_LINK] = 1'b1;
      `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: alu_op[`ALU_XOR] = 1'b1;  // Compare
      `OP_SLTI:                               alu_op[`ALU_SLT] = 1'b1;
      `OP_SLTIU:                              alu_op[`ALU_SLTU] = 1'b1;
      `OP_ANDI:                               alu_op[`ALU_AND] = 1'b1;
      `OP_ORI:                                alu_op[`ALU_OR] = 1'b1;
      `OP_XORI:                               alu_op[`ALU_XOR] = 1'b1;
      `OP_LUI:                                alu_op[`ALU_LUI] = 1'b1;
      default:                                alu_op[`ALU_ADD] = 1'b1;
    endcase
  end

  // Logical immediates are zero-extended
  assign immed = (opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI}) ? {1'b0, inst[15:0]}
                                                               : {inst[15], inst[15:0]};

  assign a_immed  = (opcode == `OP_SPECIAL) && (funct[5:2] == `FN_SHIFT_I);
  assign bi_immed = (opcode[5:3] != 3'b000) && (opcode != `OP_SPECIAL2);

  always_comb begin
    width       = width_t'(1 << `WID_NONE);
    dsign_s     = 1'b0;
    selc_s      = `SC_ALUREGM;
    dread_s     = 1'b0;
    dwrite_s    = 1'b0;
    rdb_drive_s = 1'b0;
    casez (opcode)
      `OP_COP0:
        if ((rs == `CP_MF) || (rs == `CP_CF))
          selc_s = `SC_DBUS;  // Data comes back on the bus
        else if ((rs == `CP_MT) || (rs == `CP_CT))
          rdb_drive_s = 1'b1;
      `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
        dread_s = 1'b1;
        selc_s  = `SC_DBUS;
        dsign_s = (opcode == `OP_LB) || (opcode == `OP_LH);
        if (opcode inside {`OP_LB, `OP_LBU})
          width = width_t'(1 << `WID_BYTE);
        else if (opcode inside {`OP_LH, `OP_LHU})
          width = width_t'(1 << `WID_HALF);
        else
          width = width_t'(1 << `WID_WORD);
      end
      `OP_LWC1, `OP_LWC2, `OP_LWC3: begin
        dread_s = 1'b1;
        width   = width_t'(1 << `WID_WORD);
      end
      `OP_SB, `OP_SH, `OP_SW: begin
        dwrite_s    = 1'b1;
        rdb_drive_s = 1'b1;
        if (opcode == `OP_SB)
          width = width_t'(1 << `WID_BYTE);
        else if (opcode == `OP_SH)
          width = width_t'(1 << `WID_HALF);
        else
          width = width_t'(1 << `WID_WORD);
      end
      `OP_SWC1, `OP_SWC2, `OP_SWC3: begin
        dwrite_s = 1'b1;  // Coprocessor drives the data
        width    = width_t'(1 << `WID_WORD);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/dcont_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module dcont_pipe (
  input  logic                 SYSCLK,
  input  logic                 rst_n,
  input  logic                 rhold,
  input  logic                 rls_hold,
  input  logic                 xcpn,
  input  dcont_pkg::reg_addr_t regc_addr_s,
  input  logic                 regc_write_s,
  input  dcont_pkg::sel_c_t    selc_s,
  input  logic                 dread_s,
  input  logic                 dwrite_s,
  input  logic                 dsign_s,
  input  logic                 rdb_drive_s,
  output dcont_pkg::reg_addr_t regc_addr_e,
  output dcont_pkg::reg_addr_t regc_addr_m,
  output dcont_pkg::reg_addr_t regc_addr_w,
  output logic                 regc_write_e,
  output logic                 regc_write_m,
  output logic                 regc_write_w,
  output dcont_pkg::sel_c_t    selc_m_r,
  output logic                 dread_e,
  output logic                 dwrite_e,
  output logic                 dsign_e,
  output logic                 rdb_driver
);
  import dcont_pkg::*;

  sel_c_t selc_e;
  logic   rdb_drive_e;

  // E and M stages, frozen by rhold
  always_ff @(posedge SYSCLK or negedge rst_n) begin
    if (!rst_n) begin
      regc_addr_e  <= '0;
      regc_write_e <= 1'b0;
      selc_e       <= `SC_ALUREGM;
      dread_e      <= 1'b0;
      dwrite_e     <= 1'b0;
      dsign_e      <= 1'b0;
      rdb_drive_e  <= 1'b0;
      regc_addr_m  <= '0;
      regc_write_m <= 1'b0;
      selc_m_r     <= `SC_ALUREGM;
      rdb_driver   <= 1'b0;
    end else if (!rhold) begin
      regc_addr_e  <= regc_addr_s;
      regc_write_e <= regc_write_s && !xcpn;  // Squash on exception
      selc_e       <= selc_s;
      dread_e      <= dread_s && !xcpn;
      dwrite_e     <= dwrite_s && !xcpn;
      dsign_e      <= dsign_s;
      rdb_drive_e  <= rdb_drive_s;
      regc_addr_m  <= regc_addr_e;
      regc_write_m <= regc_write_e && !xcpn;
      selc_m_r     <= selc_e;
      rdb_driver   <= rdb_drive_e;
    end
  end

  always_ff @(posedge SYSCLK or negedge rst_n) begin
    if (!rst_n) begin
      regc_addr_w  <= '0;
      regc_write_w <= 1'b0;
    end else if (!rls_hold) begin
      regc_addr_w  <= regc_addr_m;
      regc_write_w <= regc_write_m;
    end
  end

endmodule

`default_nettype wire

//--- logic/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module operand_bypass (
  input  logic                 SYSCLK,
  input  logic                 rst_n,
  input  logic                 rhold,
  input  logic                 dload,
  input  logic                 a_immed,
  input  logic                 bi_immed,
  input  dcont_pkg::reg_addr_t rega_addr,
  input  dcont_pkg::reg_addr_t regb_addr,
  input  dcont_pkg::reg_addr_t regc_addr_e,
  input  dcont_pkg::reg_addr_t regc_addr_m,
  input  dcont_pkg::reg_addr_t regc_addr_w,
  input  logic                 regc_write_e,
  input  logic                 regc_write_m,
  input  logic                 regc_write_w,
  input  dcont_pkg::sel_c_t    selc_m_r,
  output dcont_pkg::sel_a_t    sel_a,
  output dcont_pkg::sel_b_t    sel_br,
  output dcont_pkg::sel_b_t    sel_bi,
  output dcont_pkg::sel_c_t    sel_c_m
);
  import dcont_pkg::*;

  sel_a_t sel_a_e;
  sel_b_t sel_br_e;
  sel_b_t sel_bi_e;
  logic   m_dbus;  // M-stage result comes from the data bus
  logic   a_hit_e;
  logic   a_hit_m;
  logic   a_hit_w;
  logic   b_hit_e;
  logic   b_hit_m;
  logic   b_hit_w;

  function automatic sel_b_t pick_b(input logic dbus_hit, input logic hold,
                                    input logic use_imm, input logic hit_e,
                                    input logic hit_m, input logic hit_w,
                                    input logic m_is_dbus);
    if (dbus_hit)
      return `SB_DBUS;
    else if (hold)
      return `SB_HOLD;
    else if (use_imm)
      return `SB_IMMED;
    else if (hit_e)
      return `SB_ALURES;
    else if (hit_m)
      return m_is_dbus ? `SB_DBUS : `SB_ALUREGM;
    else if (hit_w)
      return `SB_REGCWB;
    else
      return `SB_REGF;
  endfunction

  always_comb begin
    if (dload)
      sel_c_m = `SC_DBUS;
    else if (rhold)
      sel_c_m = `SC_HOLD;
    else
      sel_c_m = selc_m_r;
  end

  assign m_dbus = (sel_c_m == `SC_DBUS);

  assign a_hit_e = regc_write_e && (rega_addr == regc_addr_e);
  assign a_hit_m = regc_write_m && (rega_addr == regc_addr_m);
  assign a_hit_w = regc_write_w && (rega_addr == regc_addr_w);
  assign b_hit_e = regc_write_e && (regb_addr == regc_addr_e);
  assign b_hit_m = regc_write_m && (regb_addr == regc_addr_m);
  assign b_hit_w = regc_write_w && (regb_addr == regc_addr_w);

  always_comb begin
    if ((sel_a_e == `SA_DBUS) && dload)
      sel_a = `SA_DBUS;  // Load data still pending
    else if (rhold)
      sel_a = `SA_HOLD;
    else if (a_immed)
      sel_a = `SA_IMMED;
    else if (a_hit_e)
      sel_a = `SA_ALURES;
    else if (a_hit_m)
      sel_a = m_dbus ? `SA_DBUS : `SA_ALUREGM;
    else if (a_hit_w)
      sel_a = `SA_REGCWB;
    else
      sel_a = `SA_REGF;
  end

  assign sel_br = pick_b((sel_br_e == `SB_DBUS) && dload, rhold, 1'b0,
                         b_hit_e, b_hit_m, b_hit_w, m_dbus);
  assign sel_bi = pick_b((sel_bi_e == `SB_DBUS) && dload, rhold, bi_immed,
                         b_hit_e, b_hit_m, b_hit_w, m_dbus);

  always_ff @(posedge SYSCLK or negedge rst_n) begin
    if (!rst_n) begin
      sel_a_e  <= `SA_REGF;
      sel_br_e <= `SB_REGF;
      sel_bi_e <= `SB_REGF;
    end else if (!rhold) begin
      sel_a_e  <= sel_a;
      sel_br_e <= sel_br;
      sel_bi_e <= sel_bi;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcont.sv
`timescale 1ns/1ps
`default_nettype none

module dcont (
  input  logic                 SYSCLK,
  input  logic                 rst_n,
  input  dcont_pkg::inst_t     inst,
  input  logic                 xcpn,
  input  logic                 rhold,
  input  logic                 rls_hold,
  input  logic                 dload,
  output dcont_pkg::reg_addr_t rega_addr,
  output dcont_pkg::reg_addr_t regb_addr,
  output dcont_pkg::alu_op_t   alu_op,
  output dcont_pkg::immed_t    immed,
  output dcont_pkg::width_t    width,
  output dcont_pkg::sel_a_t    sel_a,
  output dcont_pkg::sel_b_t    sel_br,
  output dcont_pkg::sel_b_t    sel_bi,
  output dcont_pkg::sel_c_t    sel_c_m,
  output logic                 dread_e,
  output logic                 dwrite_e,
  output logic                 dsign_e,
  output logic                 rdb_driver,
  output dcont_pkg::reg_addr_t regc_addr_m,
  output logic                 regc_write_m
);
  import dcont_pkg::*;

  reg_addr_t regc_addr_s;
  reg_addr_t regc_addr_e;
  reg_addr_t regc_addr_w;
  logic      regc_write_s;
  logic      regc_write_e;
  logic      regc_write_w;
  sel_c_t    selc_s;
  sel_c_t    selc_m_r;
  logic      dsign_s;
  logic      dread_s;
  logic      dwrite_s;
  logic      rdb_drive_s;
  logic      a_immed;
  logic      bi_immed;

  reg_addr_decode reg_addr_decode_i (
    .inst         (inst),
    .rega_addr    (rega_addr),
    .regb_addr    (regb_addr),
    .regc_addr_s  (regc_addr_s),
    .regc_write_s (regc_write_s)
  );

  exec_decode exec_decode_i (
    .inst        (inst),
    .alu_op      (alu_op),
    .immed       (immed),
    .width       (width),
    .selc_s      (selc_s),
    .dsign_s     (dsign_s),
    .dread_s     (dread_s),
    .dwrite_s    (dwrite_s),
    .rdb_drive_s (rdb_drive_s),
    .a_immed     (a_immed),
    .bi_immed    (bi_immed)
  );

  dcont_pipe dcont_pipe_i (
    .SYSCLK       (SYSCLK),
    .rst_n        (rst_n),
    .rhold        (rhold),
    .rls_hold     (rls_hold),
    .xcpn         (xcpn),
    .regc_addr_s  (regc_addr_s),
    .regc_write_s (regc_write_s),
    .selc_s       (selc_s),
    .dread_s      (dread_s),
    .dwrite_s     (dwrite_s),
    .dsign_s      (dsign_s),
    .rdb_drive_s  (rdb_drive_s),
    .regc_addr_e  (regc_addr_e),
    .regc_addr_m  (regc_addr_m),
    .regc_addr_w  (regc_addr_w),
    .regc_write_e (regc_write_e),
    .regc_write_m (regc_write_m),
    .regc_write_w (regc_write_w),
    .selc_m_r     (selc_m_r),
    .dread_e      (dread_e),
    .dwrite_e     (dwrite_e),
    .dsign_e      (dsign_e),
    .rdb_driver   (rdb_driver)
  );

  operand_bypass operand_bypass_i (
    .SYSCLK       (SYSCLK),
    .rst_n        (rst_n),
    .rhold        (rhold),
    .dload        (dload),
    .a_immed      (a_immed),
    .bi_immed     (bi_immed),
    .rega_addr    (rega_addr),
    .regb_addr    (regb_addr),
    .regc_addr_e  (regc_addr_e),
    .regc_addr_m  (regc_addr_m),
    .regc_addr_w  (regc_addr_w),
    .regc_write_e (regc_write_e),
    .regc_write_m (regc_write_m),
    .regc_write_w (regc_write_w),
    .selc_m_r     (selc_m_r),
    .sel_a        (sel_a),
    .sel_br       (sel_br),
    .sel_bi       (sel_bi),
    .sel_c_m      (sel_c_m)
  );

endmodule

`default_nettype wire

//--- sim/dcont_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module dcont_asserts (
  input logic                 SYSCLK,
  input logic                 rst_n,
  input logic                 rhold,
  input logic                 dload,
  input dcont_pkg::sel_a_t    sel_a,
  input dcont_pkg::sel_c_t    sel_c_m,
  input logic                 dread_e,
  input logic                 dwrite_e,
  input logic                 rdb_driver,
  input dcont_pkg::reg_addr_t regc_addr_m,
  input logic                 regc_write_m
);
  import dcont_pkg::*;

  int unsigned fail_cnt = 0;  // Read by the testbench

  reset_quiet: assert property (@(posedge SYSCLK)
    $rose(rst_n) |-> !dread_e && !dwrite_e && !rdb_driver && !regc_write_m)
    else begin
      $error("control outputs active right after reset");
      fail_cnt++;
    end

  rd_wr_excl: assert property (@(posedge SYSCLK) disable iff (!rst_n)
    !(dread_e && dwrite_e))
    else begin
      $error("dread_e and dwrite_e high together");
      fail_cnt++;
    end

  no_r0_write: assert property (@(posedge SYSCLK) disable iff (!rst_n)
    regc_write_m |-> (regc_addr_m != `REG_ZERO))
    else begin
      $error("register 0 written in M stage");
      fail_cnt++;
    end

  hold_sel_a: assert property (@(posedge SYSCLK) disable iff (!rst_n)
    rhold |-> (sel_a == `SA_HOLD) || (dload && (sel_a == `SA_DBUS)))
    else begin
      $error("sel_a not HOLD during rhold");
      fail_cnt++;
    end

  load_sel_c: assert property (@(posedge SYSCLK) disable iff (!rst_n)
    dload |-> (sel_c_m == `SC_DBUS))
    else begin
      $error("sel_c_m not DBUS during dload");
      fail_cnt++;
    end

endmodule

bind dcont dcont_asserts asserts_i (.*);

`default_nettype wire

//--- sim/dcont_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcont_config.svh"

module dcont_tb;
  import dcont_pkg::*;

  localparam int         max_cycles = 2000;  // Tests take about 120 cycles
  localparam inst_t      nop_inst   = '0;
  localparam logic [5:0] fn_addu    = 6'h21;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [3:0] ctl_xcpn   = 4'b1000;  // {xcpn, rhold, rls_hold, dload}
  localparam logic [3:0] ctl_rhold  = 4'b0100;
  localparam logic [3:0] ctl_rls    = 4'b0010;
  localparam logic [3:0] ctl_dload  = 4'b0001;

  logic      SYSCLK;
  logic      rst_n;
  inst_t     inst;
  logic      xcpn, rhold, rls_hold, dload;
  reg_addr_t rega_addr, regb_addr, regc_addr_m;
  alu_op_t   alu_op;
  immed_t    immed;
  width_t    width;
  sel_a_t    sel_a;
  sel_b_t    sel_br, sel_bi;
  sel_c_t    sel_c_m;
  logic      dread_e, dwrite_e, dsign_e, rdb_driver, regc_write_m;

  int         seed   = 60;
  int         errors = 0;
  int         tests  = 0;
  int         cycles = 0;
  logic       track  = 1'b0;  // Compare M-stage destination against the queue
  logic [5:0] exp_q[$];       // {write, addr} of the last three instructions

  dcont dut_i (.*);

  initial SYSCLK = 1'b0;
  always #5 SYSCLK = ~SYSCLK;

  always @(posedge SYSCLK) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not end within %0d cycles", max_cycles);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(1 + ($unsigned($random(seed)) % 30));
  endfunction

  function automatic inst_t rtype(input reg_addr_t rs, rt, rd, input logic [5:0] fn);
    return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic inst_t itype(input logic [5:0] op, input reg_addr_t rs, rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Destination rules for the opcodes used here
  function automatic logic [5:0] dest_of(input inst_t i);
    logic [5:0] op;
    reg_addr_t  d;
    logic       wr;
    op = i[31:26];
    d  = (op == `OP_SPECIAL) ? i[15:11] : (op == `OP_JAL) ? `REG_LINK : i[20:16];
    wr = !(op inside {`OP_BEQ, `OP_BNE, `OP_J, `OP_SB, `OP_SH, `OP_SW})
         && !((op == `OP_SPECIAL) && (i[5:0] == `FN_JR));
    return {wr && (d != `REG_ZERO), d};
  endfunction

  function automatic int alu_bit_of(input inst_t i);
    case (i[31:26])
      `OP_SPECIAL: return (i[5:0] == `FN_SUB) ? `ALU_SUB : (i[5:0] == `FN_AND) ? `ALU_AND
                                                                              : `ALU_ADD;
      `OP_BEQ, `OP_XORI: return `ALU_XOR;
      `OP_JAL:           return `ALU_LINK;
      `OP_LUI:           return `ALU_LUI;
      `OP_ANDI:          return `ALU_AND;
      `OP_ORI:           return `ALU_OR;
      `OP_SLTI:          return `ALU_SLT;
      default:           return `ALU_ADD;
    endcase
  endfunction

  // {store, signed, width bit}
  function automatic logic [3:0] mem_ref(input logic [5:0] op);
    case (op)
      `OP_LB:  return {2'b01, 2'(`WID_BYTE)};
      `OP_LBU: return {2'b00, 2'(`WID_BYTE)};
      `OP_LH:  return {2'b01, 2'(`WID_HALF)};
      `OP_LHU: return {2'b00, 2'(`WID_HALF)};
      `OP_SB:  return {2'b10, 2'(`WID_BYTE)};
      `OP_SH:  return {2'b10, 2'(`WID_HALF)};
      `OP_SW:  return {2'b10, 2'(`WID_WORD)};
      default: return {2'b00, 2'(`WID_WORD)};
    endcase
  endfunction

  task automatic check_eq(input logic [31:0] got, exp, input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Drive on the falling edge, then let the decode settle
  task automatic issue(input inst_t i, input logic [3:0] ctl = 4'b0000);
    logic [5:0] old;
    @(negedge SYSCLK);
    inst = i;
    {xcpn, rhold, rls_hold, dload} = ctl;
    #1;
    exp_q.push_back(dest_of(i));
    if (exp_q.size() == 3) begin
      old = exp_q.pop_front();
      if (track) begin
        check_eq(regc_addr_m, old[4:0], "regc_addr_m");
        check_eq(regc_write_m, old[5], "regc_write_m");
      end
    end
  endtask

  task automatic drain();
    repeat (3) issue(nop_inst);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests++;
    $display("test %-10s %s", name, (errors == errs_at_start) ? "ok" : "FAILED");
  endtask

  initial begin
    int          e0;
    int          d;
    reg_addr_t   r;
    logic [15:0] imm;
    immed_t      ext;
    inst_t       i;
    inst_t       prog[$];
    logic [5:0]  ops[$];
    logic [3:0]  ref_m;
    sel_a_t      exp_a;
    sel_b_t      exp_b;
    rst_n    = 1'b0;
    inst     = '0;
    xcpn     = 1'b0;
    rhold    = 1'b0;
    rls_hold = 1'b0;
    dload    = 1'b0;
    repeat (3) @(posedge SYSCLK);
    @(negedge SYSCLK);
    rst_n = 1'b1;
    track = 1'b1;

    e0   = errors;
    prog = {rtype(rand_reg(), rand_reg(), 5'd0, `FN_AND),
            rtype(rand_reg(), rand_reg(), rand_reg(), `FN_SUB),
            itype(`OP_JAL, rand_reg(), rand_reg(), 16'h0040),
            itype(`OP_SW, rand_reg(), rand_reg(), 16'h0008),
            itype(`OP_BEQ, rand_reg(), rand_reg(), 16'hfffc),
            rtype(rand_reg(), 5'd0, rand_reg(), `FN_JR)};
    foreach (prog[k]) begin
      issue(prog[k]);
      check_eq(rega_addr, prog[k][25:21], "rega_addr");
      check_eq(regb_addr, prog[k][20:16], "regb_addr");
    end
    drain();
    report_test("regdecode", e0);

    e0  = errors;
    ops = {`OP_SPECIAL, op_addiu, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
           `OP_BEQ, `OP_JAL, `OP_LW};
    foreach (ops[k]) begin
      for (int n = 0; n < 2; n++) begin
        imm     = 16'($random(seed));
        imm[15] = (n == 1);  // One negative value per opcode
        if (ops[k] == `OP_SPECIAL)
          imm[5:0] = (n == 1) ? `FN_SUB : `FN_AND;
        i = itype(ops[k], rand_reg(), rand_reg(), imm);
        issue(i);
        check_eq(alu_op, 1 << alu_bit_of(i), "alu_op");
        ext = (ops[k] inside {`OP_ANDI, `OP_ORI, `OP_XORI}) ? {1'b0, imm} : {imm[15], imm};
        check_eq(immed, ext, "immed");
      end
    end
    drain();
    report_test("aluimm", e0);

    e0  = errors;
    ops = {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW};
    foreach (ops[k]) begin
      ref_m = mem_ref(ops[k]);
      issue(itype(ops[k], rand_reg(), rand_reg(), 16'($random(seed))));
      check_eq(width, 1 << ref_m[1:0], "width");
      issue(nop_inst);
      check_eq(dread_e, !ref_m[3], "dread_e");
      check_eq(dwrite_e, ref_m[3], "dwrite_e");
      check_eq(dsign_e, ref_m[2], "dsign_e");
      issue(nop_inst);
      check_eq(rdb_driver, ref_m[3], "rdb_driver");
    end
    drain();
    report_test("memctl", e0);

    e0 = errors;
    for (d = 1; d <= 4; d++) begin
      r = rand_reg();
      if (d == 4)
        issue(itype(`OP_LW, 5'd0, r, 16'h0010));  // Load result comes back on the bus
      else
        issue(rtype(5'd0, 5'd0, r, fn_addu));
      repeat ((d == 4) ? 1 : d - 1) issue(nop_inst);
      issue(rtype(r, r, 5'd0, fn_addu));
      exp_a = (d == 1) ? `SA_ALURES : (d == 2) ? `SA_ALUREGM : (d == 3) ? `SA_REGCWB
                                                                      : `SA_DBUS;
      exp_b = (d == 1) ? `SB_ALURES : (d == 2) ? `SB_ALUREGM : (d == 3) ? `SB_REGCWB
                                                                      : `SB_DBUS;
      check_eq(sel_a, exp_a, "sel_a");
      check_eq(sel_br, exp_b, "sel_br");
      drain();
    end
    r = rand_reg();
    issue(rtype(5'd0, 5'd0, r, fn_addu));
    issue(itype(`OP_ORI, r, r, 16'h00ff));
    check_eq(sel_bi, `SB_IMMED, "sel_bi");
    check_eq(sel_br, `SB_ALURES, "sel_br");
    drain();
    report_test("forward", e0);

    e0    = errors;
    track = 1'b0;
    issue(itype(`OP_LW, 5'd0, rand_reg(), 16'h0004), ctl_xcpn);
    issue(nop_inst);
    check_eq(dread_e, 1'b0, "dread_e");
    issue(nop_inst);
    check_eq(regc_write_m, 1'b0, "regc_write_m");
    drain();
    report_test("squash", e0);

    e0 = errors;
    r  = rand_reg();
    issue(itype(`OP_LW, 5'd0, r, 16'h0020));
    issue(itype(`OP_LW, 5'd0, ~r, 16'h0024));  // Second load sits in E
    repeat (4) begin
      issue(nop_inst, ctl_rhold);
      check_eq(dread_e, 1'b1, "dread_e");
      check_eq(regc_addr_m, r, "regc_addr_m");
      check_eq(sel_a, `SA_HOLD, "sel_a");
    end
    issue(nop_inst, ctl_rhold | ctl_dload);
    check_eq(sel_c_m, `SC_DBUS, "sel_c_m");
    drain();
    r = rand_reg();
    issue(rtype(5'd0, 5'd0, r, fn_addu));
    repeat (2) issue(nop_inst);
    repeat (2) issue(nop_inst, ctl_rls);  // W keeps the writer
    issue(rtype(r, r, 5'd0, fn_addu), ctl_rls);
    check_eq(sel_a, `SA_REGCWB, "sel_a");
    check_eq(sel_br, `SB_REGCWB, "sel_br");
    drain();
    report_test("holds", e0);

    $display("tests: %0d, check errors: %0d, assertion failures: %0d",
             tests, errors, dut_i.asserts_i.fail_cnt);
    if ((errors == 0) && (dut_i.asserts_i.fail_cnt == 0))
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/dcont_pkg.sv
logic/reg_addr_decode.sv
logic/exec_decode.sv
logic/dcont_pipe.sv
logic/operand_bypass.sv
logic/dcont.sv
sim/dcont_asserts.sv
sim/dcont_tb.sv

//--- Bender.yml
package:
  name: dcont

sources:
  - include_dirs:
      - logic
    files:
      - logic/dcont_pkg.sv
      - logic/reg_addr_decode.sv
      - logic/exec_decode.sv
      - logic/dcont_pipe.sv
      - logic/operand_bypass.sv
      - logic/dcont.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/dcont_asserts.sv
      - sim/dcont_tb.sv
